// File: design/render_pkg.sv
`default_nettype none

package render_pkg;

  // ************************************************************
  // Frame geometry
  // ************************************************************
  localparam int H_PIXELS = 16;
  localparam int V_LINES = 8;
  localparam int H_BITS = $clog2(H_PIXELS);
  localparam int V_BITS = $clog2(V_LINES);
  localparam int ADDR_BITS = 7;             // H_BITS + V_BITS
  localparam int PIXELS = H_PIXELS * V_LINES;
  localparam int COLOR_BITS = 4;

  // Frame counting
  localparam int COUNT_BITS = 16;
  localparam int RATE_WINDOW = 1024;        // Cycles per rate window
  localparam int WINDOW_BITS = $clog2(RATE_WINDOW);

  // ************************************************************
  // APB register map
  // ************************************************************
  localparam int APB_ADDR_BITS = 8;
  localparam int APB_DATA_BITS = 32;

  localparam logic [APB_ADDR_BITS-1:0] REG_CTRL = 8'h00;
  localparam logic [APB_ADDR_BITS-1:0] REG_COLORS = 8'h04;
  localparam logic [APB_ADDR_BITS-1:0] REG_STATUS = 8'h08;
  localparam logic [APB_ADDR_BITS-1:0] REG_FRAME_COUNT = 8'h0C;
  localparam logic [APB_ADDR_BITS-1:0] REG_FRAME_RATE = 8'h10;

  typedef enum logic [1:0] {
    SHADE_SOLID = 2'd0,
    SHADE_CHECKER = 2'd1,
    SHADE_GRADIENT = 2'd2
  } shade_mode_e;

  typedef enum logic [1:0] {
    SRC_IDLE,
    SRC_DRAW,
    SRC_WAIT_SWAP
  } src_state_e;

  typedef enum logic {
    SCAN_IDLE,
    SCAN_RUN
  } scan_state_e;

endpackage

`default_nettype wire

// File: design/apb_render_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_render_regs (
  input wire sys_clk,
  input wire sys_rst,
  input wire psel,
  input wire penable,
  input wire pwrite,
  input wire [render_pkg::APB_ADDR_BITS-1:0] paddr,
  input wire [render_pkg::APB_DATA_BITS-1:0] pwdata,
  output logic [render_pkg::APB_DATA_BITS-1:0] prdata,
  output logic pready,
  output logic pslverr,
  input wire swap,
  input wire busy,
  input wire [render_pkg::COUNT_BITS-1:0] frame_rate,
  output logic enable,
  output render_pkg::shade_mode_e mode,
  output logic [render_pkg::COLOR_BITS-1:0] fg_color,
  output logic [render_pkg::COLOR_BITS-1:0] bg_color,
  output logic [render_pkg::COUNT_BITS-1:0] frame_count
);

  logic access;
  logic addr_ok;
  logic read_only;
  logic wr_ok;

  assign access = psel && penable;
  assign pready = 1'b1;  // Zero wait states

  // ************************************************************
  // Address decode and read mux
  // ************************************************************
  always_comb begin
    addr_ok = 1'b1;
    read_only = 1'b0;
    prdata = '0;
    case (paddr)
      render_pkg::REG_CTRL: begin
        prdata[2:0] = {mode, enable};
      end
      render_pkg::REG_COLORS: begin
        prdata[2*render_pkg::COLOR_BITS-1:0] = {bg_color, fg_color};
      end
      render_pkg::REG_STATUS: begin
        prdata[0] = busy;
        read_only = 1'b1;
      end
      render_pkg::REG_FRAME_COUNT: begin
        prdata[render_pkg::COUNT_BITS-1:0] = frame_count;
        read_only = 1'b1;
      end
      render_pkg::REG_FRAME_RATE: begin
        prdata[render_pkg::COUNT_BITS-1:0] = frame_rate;
        read_only = 1'b1;
      end
      default: addr_ok = 1'b0;
    endcase
  end

  assign pslverr = access && (!addr_ok || (pwrite && read_only));
  assign wr_ok = access && pwrite && addr_ok && !read_only;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      enable <= 1'b0;
      mode <= render_pkg::SHADE_SOLID;
      fg_color <= '0;
      bg_color <= '0;
    end else if (wr_ok) begin
      if (paddr == render_pkg::REG_CTRL) begin
        enable <= pwdata[0];
        mode <= render_pkg::shade_mode_e'(pwdata[2:1]);
      end
      if (paddr == render_pkg::REG_COLORS) begin
        fg_color <= pwdata[render_pkg::COLOR_BITS-1:0];
        bg_color <= pwdata[2*render_pkg::COLOR_BITS-1:render_pkg::COLOR_BITS];
      end
    end
  end

  // One count per buffer swap
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      frame_count <= '0;
    end else if (swap) begin
      frame_count <= frame_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/pixel_source.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_source (
  input wire sys_clk,
  input wire sys_rst,
  input wire enable,
  input wire render_pkg::shade_mode_e mode,
  input wire [render_pkg::COLOR_BITS-1:0] fg_color,
  input wire [render_pkg::COLOR_BITS-1:0] bg_color,
  input wire [render_pkg::COUNT_BITS-1:0] frame_count,
  input wire swap,
  output logic wr_en,
  output logic [render_pkg::ADDR_BITS-1:0] wr_addr,
  output logic [render_pkg::COLOR_BITS-1:0] wr_color,
  output logic frame_done
);

  render_pkg::src_state_e state;
  logic [render_pkg::H_BITS-1:0] h;
  logic [render_pkg::V_BITS-1:0] v;
  logic last_pixel;

  // Configuration held for the whole frame
  render_pkg::shade_mode_e cfg_mode;
  logic [render_pkg::COLOR_BITS-1:0] cfg_fg;
  logic [render_pkg::COLOR_BITS-1:0] cfg_bg;
  logic [render_pkg::COLOR_BITS-1:0] cfg_frame;

  assign last_pixel = (&h) && (&v);

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state <= render_pkg::SRC_IDLE;
      h <= '0;
      v <= '0;
    end else begin
      case (state)
        render_pkg::SRC_IDLE: begin
          if (enable) state <= render_pkg::SRC_DRAW;
        end
        render_pkg::SRC_DRAW: begin
          h <= h + 1'b1;          // Wraps at end of line
          if (&h) v <= v + 1'b1;
          if (last_pixel) state <= render_pkg::SRC_WAIT_SWAP;
        end
        render_pkg::SRC_WAIT_SWAP: begin
          if (swap) state <= enable ? render_pkg::SRC_DRAW : render_pkg::SRC_IDLE;
        end
        default: state <= render_pkg::SRC_IDLE;
      endcase
    end
  end

  // Latch at frame start
  always_ff @(posedge sys_clk) begin
    if (state == render_pkg::SRC_IDLE && enable) begin
      cfg_mode <= mode;
      cfg_fg <= fg_color;
      cfg_bg <= bg_color;
      cfg_frame <= frame_count[render_pkg::COLOR_BITS-1:0];
    end else if (state == render_pkg::SRC_WAIT_SWAP && swap) begin
      cfg_mode <= mode;
      cfg_fg <= fg_color;
      cfg_bg <= bg_color;
      // Frame count steps on this same swap
      cfg_frame <= frame_count[render_pkg::COLOR_BITS-1:0] + 1'b1;
    end
  end

  // ************************************************************
  // Shading in the same cycle as the write
  // ************************************************************
  always_comb begin
    case (cfg_mode)
      render_pkg::SHADE_CHECKER: wr_color = (h[1] ^ v[1]) ? cfg_fg : cfg_bg;
      render_pkg::SHADE_GRADIENT: begin
        wr_color = render_pkg::COLOR_BITS'(h) + render_pkg::COLOR_BITS'(v) + cfg_frame;
      end
      default: wr_color = cfg_fg;
    endcase
  end

  assign wr_en = (state == render_pkg::SRC_DRAW);
  assign wr_addr = {v, h};  // v * 16 + h
  assign frame_done = (state == render_pkg::SRC_WAIT_SWAP);

endmodule

`default_nettype wire

// File: design/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
  input wire sys_clk,
  input wire sys_rst,
  input wire swap,
  input wire wr_en,
  input wire [render_pkg::ADDR_BITS-1:0] wr_addr,
  input wire [render_pkg::COLOR_BITS-1:0] wr_color,
  input wire [render_pkg::ADDR_BITS-1:0] rd_addr,
  output logic [render_pkg::COLOR_BITS-1:0] rd_color
);

  // Front and back pixel memories
  logic [render_pkg::COLOR_BITS-1:0] mem [2][render_pkg::PIXELS];
  logic front_sel;  // Memory currently shown

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      front_sel <= 1'b0;
    end else if (swap) begin
      front_sel <= ~front_sel;
    end
  end

  // ************************************************************
  // Back buffer write port
  // ************************************************************
  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      mem[~front_sel][wr_addr] <= wr_color;
    end
  end

  // Front buffer read with one cycle of latency
  always_ff @(posedge sys_clk) begin
    rd_color <= mem[front_sel][rd_addr];
  end

endmodule

`default_nettype wire

// File: design/scan_reader.sv
`timescale 1ns/1ps
`default_nettype none

module scan_reader (
  input wire sys_clk,
  input wire sys_rst,
  input wire swap,
  input wire [render_pkg::COLOR_BITS-1:0] rd_color,
  output logic [render_pkg::ADDR_BITS-1:0] rd_addr,
  output logic scan_busy,
  output logic pix_valid,
  output logic pix_sof,
  output logic [render_pkg::COLOR_BITS-1:0] pix_color
);

  render_pkg::scan_state_e state;
  logic last_addr;

  assign scan_busy = (state == render_pkg::SCAN_RUN);
  assign last_addr = (rd_addr == render_pkg::ADDR_BITS'(render_pkg::PIXELS - 1));

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state <= render_pkg::SCAN_IDLE;
      rd_addr <= '0;
    end else begin
      case (state)
        render_pkg::SCAN_IDLE: begin
          if (swap) begin
            state <= render_pkg::SCAN_RUN;
            rd_addr <= '0;
          end
        end
        render_pkg::SCAN_RUN: begin
          rd_addr <= rd_addr + 1'b1;  // Back to 0 after the last pixel
          if (last_addr) state <= render_pkg::SCAN_IDLE;
        end
        default: state <= render_pkg::SCAN_IDLE;
      endcase
    end
  end

  // ************************************************************
  // Delay stage matching memory latency
  // ************************************************************
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      pix_valid <= 1'b0;
      pix_sof <= 1'b0;
    end else begin
      pix_valid <= scan_busy;
      pix_sof <= scan_busy && (rd_addr == '0);
    end
  end

  assign pix_color = rd_color;  // Already registered in the buffer

endmodule

`default_nettype wire

// File: design/frame_rate_counter.sv
`timescale 1ns/1ps
`default_nettype none

module frame_rate_counter (
  input wire sys_clk,
  input wire sys_rst,
  input wire swap,
  output logic [render_pkg::COUNT_BITS-1:0] frame_rate
);

  logic [render_pkg::WINDOW_BITS-1:0] win_cnt;
  logic [render_pkg::COUNT_BITS-1:0] swap_cnt;
  logic win_end;

  assign win_end = (win_cnt == render_pkg::WINDOW_BITS'(render_pkg::RATE_WINDOW - 1));

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      win_cnt <= '0;
      swap_cnt <= '0;
      frame_rate <= '0;
    end else begin
      win_cnt <= win_cnt + 1'b1;  // Free running window
      if (win_end) begin
        // Include a swap on the window's last cycle
        frame_rate <= swap_cnt + render_pkg::COUNT_BITS'(swap);
        swap_cnt <= '0;
      end else begin
        swap_cnt <= swap_cnt + render_pkg::COUNT_BITS'(swap);
      end
    end
  end

endmodule

`default_nettype wire

// File: design/render_top.sv
`timescale 1ns/1ps
`default_nettype none

module render_top (
  input wire sys_clk,
  input wire sys_rst,
  input wire psel,
  input wire penable,
  input wire pwrite,
  input wire [render_pkg::APB_ADDR_BITS-1:0] paddr,
  input wire [render_pkg::APB_DATA_BITS-1:0] pwdata,
  output logic [render_pkg::APB_DATA_BITS-1:0] prdata,
  output logic pready,
  output logic pslverr,
  output logic pix_valid,
  output logic pix_sof,
  output logic [render_pkg::COLOR_BITS-1:0] pix_color
);

  // Control path
  logic enable;
  render_pkg::shade_mode_e mode;
  logic [render_pkg::COLOR_BITS-1:0] fg_color;
  logic [render_pkg::COLOR_BITS-1:0] bg_color;
  logic [render_pkg::COUNT_BITS-1:0] frame_count;
  logic [render_pkg::COUNT_BITS-1:0] frame_rate;
  logic busy;

  // Frame store traffic
  logic wr_en;
  logic [render_pkg::ADDR_BITS-1:0] wr_addr;
  logic [render_pkg::COLOR_BITS-1:0] wr_color;
  logic [render_pkg::ADDR_BITS-1:0] rd_addr;
  logic [render_pkg::COLOR_BITS-1:0] rd_color;
  logic frame_done;
  logic scan_busy;
  logic swap;

  // ************************************************************
  // Swap when the back frame is complete and the scan is free
  // ************************************************************
  assign swap = frame_done && !scan_busy;
  assign busy = wr_en || frame_done || scan_busy;  // Source not idle, or scanning

  apb_render_regs regs_inst (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .swap(swap),
    .busy(busy),
    .frame_rate(frame_rate),
    .enable(enable),
    .mode(mode),
    .fg_color(fg_color),
    .bg_color(bg_color),
    .frame_count(frame_count)
  );

  pixel_source source_inst (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .enable(enable),
    .mode(mode),
    .fg_color(fg_color),
    .bg_color(bg_color),
    .frame_count(frame_count),
    .swap(swap),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_color(wr_color),
    .frame_done(frame_done)
  );

  frame_buffer buffer_inst (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .swap(swap),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_color(wr_color),
    .rd_addr(rd_addr),
    .rd_color(rd_color)
  );

  scan_reader scan_inst (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .swap(swap),
    .rd_color(rd_color),
    .rd_addr(rd_addr),
    .scan_busy(scan_busy),
    .pix_valid(pix_valid),
    .pix_sof(pix_sof),
    .pix_color(pix_color)
  );

  frame_rate_counter rate_inst (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .swap(swap),
    .frame_rate(frame_rate)
  );

endmodule

`default_nettype wire

// File: dv/render_tb_sva.sv
`timescale 1ns/1ps
`default_nettype none

module render_tb_sva (
  input wire sys_clk,
  input wire sys_rst,
  input wire psel,
  input wire penable,
  input wire pready,
  input wire pix_valid,
  input wire pix_sof
);

  logic [6:0] since_sof;  // Saturates at 127

  always_ff @(posedge sys_clk) begin
    if (sys_rst || (!pix_sof && since_sof != 7'd127)) begin
      since_sof <= sys_rst ? 7'd127 : since_sof + 1'b1;
    end else if (pix_sof) begin
      since_sof <= '0;
    end
  end

  ap_pready: assert property (@(posedge sys_clk) disable iff (sys_rst)
    psel && penable |-> pready) else $error("pready low in access phase");

  ap_sof_valid: assert property (@(posedge sys_clk) disable iff (sys_rst)
    pix_sof |-> pix_valid) else $error("pix_sof without pix_valid");

  ap_reset_valid: assert property (@(posedge sys_clk)
    $fell(sys_rst) |-> !pix_valid) else $error("pix_valid high after reset");

  ap_sof_spacing: assert property (@(posedge sys_clk) disable iff (sys_rst)
    pix_sof |-> since_sof == 7'd127) else $error("pix_sof too close to previous one");

endmodule

bind render_top render_tb_sva sva_i (
  .sys_clk(sys_clk),
  .sys_rst(sys_rst),
  .psel(psel),
  .penable(penable),
  .pready(pready),
  .pix_valid(pix_valid),
  .pix_sof(pix_sof)
);

`default_nettype wire

// File: dv/render_tb.sv
`timescale 1ns/1ps
`default_nettype none

module render_tb;

  localparam int CLK_NS = 40;
  localparam int CONFIGS = 20;
  localparam int FRAMES_PER_CONFIG = 6;
  localparam longint WATCHDOG_NS = longint'(CONFIGS) * FRAMES_PER_CONFIG * 300 * CLK_NS + 400000;

  logic sys_clk;
  logic sys_rst;
  logic psel;
  logic penable;
  logic pwrite;
  logic [7:0] paddr;
  logic [31:0] pwdata;
  wire [31:0] prdata;
  wire pready;
  wire pslverr;
  wire pix_valid;
  wire pix_sof;
  wire [3:0] pix_color;

  // Model state
  int errors = 0;
  int checks = 0;
  int cyc = 0;
  int sof_count = 0;
  int sofs_in_window[int];
  int rate_cyc[$];
  int rate_val[$];
  int cur_mode = 0;
  int cur_fg = 0;
  int cur_bg = 0;
  bit idle_expect = 0;
  bit in_frame = 0;
  int pix_idx = 0;
  int frame_f = 0;

  render_top dut_i (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .pix_valid(pix_valid),
    .pix_sof(pix_sof),
    .pix_color(pix_color)
  );

  initial begin
    sys_clk = 1'b0;
    forever #(CLK_NS / 2) sys_clk = ~sys_clk;
  end

  // Cycle number of the values sampled at each edge
  always @(posedge sys_clk) cyc <= sys_rst ? 0 : cyc + 1;

  task automatic check_value(input string name, input int exp, input int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("ERR %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic report_fault(input string what);
    errors++;
    $display("Failure at cycle %0d: %s", cyc, what);
  endtask

  // Shading rule with h the column, v the line and f the frame index
  function automatic int shade(input int mode, input int fg, input int bg, input int idx,
                               input int f);
    int h;
    int v;
    h = idx % 16;
    v = idx / 16;
    case (mode)
      1: shade = (((h ^ v) >> 1) & 1) ? fg : bg;
      2: shade = (h + v + f) % 16;
      default: shade = fg;
    endcase
  endfunction

  // ************************************************************
  // APB master
  // ************************************************************
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output bit err);
    @(posedge sys_clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b1;
    paddr <= addr;
    pwdata <= data;
    @(posedge sys_clk);
    penable <= 1'b1;
    @(posedge sys_clk);
    err = pslverr;
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output bit err,
                          output int at_cyc);
    @(posedge sys_clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= addr;
    @(posedge sys_clk);
    penable <= 1'b1;
    @(posedge sys_clk);
    data = prdata;
    err = pslverr;
    at_cyc = cyc;  // Access phase cycle
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_not_busy();
    logic [31:0] data;
    bit err;
    int at;
    data = 32'h1;
    while (data[0]) apb_read(8'h08, data, err, at);
  endtask

  // ************************************************************
  // Stream monitor
  // ************************************************************
  always @(posedge sys_clk) begin
    if (!sys_rst) begin
      if (pix_valid && idle_expect) report_fault("pixel stream active after busy went low");
      if (pix_valid) begin
        if (pix_sof) begin
          if (in_frame) report_fault($sformatf("frame cut short at pixel %0d", pix_idx));
          in_frame = 1;
          pix_idx = 0;
          frame_f = sof_count;
          sof_count++;
          // Swap came 2 cycles before sof
          if (sofs_in_window.exists((cyc - 2) / 1024)) sofs_in_window[(cyc - 2) / 1024]++;
          else sofs_in_window[(cyc - 2) / 1024] = 1;
        end else if (!in_frame) begin
          report_fault("pixel outside a frame");
        end
        if (in_frame) begin
          check_value("pixel", shade(cur_mode, cur_fg, cur_bg, pix_idx, frame_f), pix_color);
          pix_idx++;
          if (pix_idx == 128) in_frame = 0;
        end
      end else if (in_frame) begin
        report_fault($sformatf("gap in frame at pixel %0d", pix_idx));
        in_frame = 0;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, simulation did not finish in %0d ns", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] data;
    logic [31:0] rdata;
    logic [7:0] addr;
    bit err;
    int at;
    int target;
    int exp_rate;
    void'($urandom(78571));
    sys_rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (4) @(posedge sys_clk);
    sys_rst <= 1'b0;

    // Register access with enable kept off
    for (int i = 0; i < 12; i++) begin
      data = $urandom() & 32'hffff_fffe;
      addr = (i % 2) ? 8'h04 : 8'h00;
      apb_write(addr, data, err);
      check_value("reg_write_err", 0, err);
      apb_read(addr, rdata, err, at);
      check_value("reg_read_err", 0, err);
      check_value("reg_readback", (i % 2) ? (data & 32'hff) : (data & 32'h6), rdata);
    end
    for (int i = 0; i < 6; i++) begin
      addr = 8'($urandom_range(255, 20));
      apb_write(addr, $urandom(), err);
      check_value("unmapped_write_err", 1, err);
      apb_read(addr, rdata, err, at);
      check_value("unmapped_read_err", 1, err);
    end
    for (int i = 0; i < 3; i++) begin
      addr = 8'(8 + 4 * i);
      apb_write(addr, $urandom(), err);
      check_value("ro_write_err", 1, err);
      apb_read(addr, rdata, err, at);
      check_value("ro_read_err", 0, err);
    end

    // ************************************************************
    // Random configurations
    // ************************************************************
    for (int c = 0; c < CONFIGS; c++) begin
      apb_write(8'h00, 32'(cur_mode << 1), err);
      wait_not_busy();
      repeat (2) @(posedge sys_clk);
      idle_expect = 1;
      apb_read(8'h0C, rdata, err, at);
      check_value("frame_count", sof_count, rdata);
      cur_mode = $urandom_range(2, 0);
      cur_fg = $urandom_range(15, 0);
      cur_bg = $urandom_range(15, 0);
      apb_write(8'h04, 32'((cur_bg << 4) | cur_fg), err);
      repeat (20) @(posedge sys_clk);
      target = sof_count + FRAMES_PER_CONFIG;
      apb_write(8'h00, 32'((cur_mode << 1) | 1), err);
      idle_expect = 0;
      apb_read(8'h00, rdata, err, at);
      check_value("ctrl_readback", (cur_mode << 1) | 1, rdata);
      while (sof_count < target) begin
        apb_read(8'h10, rdata, err, at);
        rate_cyc.push_back(at);
        rate_val.push_back(rdata);
        repeat ($urandom_range(200, 20)) @(posedge sys_clk);
      end
    end
    apb_write(8'h00, 32'(cur_mode << 1), err);
    wait_not_busy();
    repeat (4) @(posedge sys_clk);
    apb_read(8'h0C, rdata, err, at);
    check_value("frame_count", sof_count, rdata);

    foreach (rate_cyc[i]) begin
      exp_rate = 0;
      if (rate_cyc[i] >= 1024 && sofs_in_window.exists(rate_cyc[i] / 1024 - 1))
        exp_rate = sofs_in_window[rate_cyc[i] / 1024 - 1];
      check_value("frame_rate", exp_rate, rate_val[i]);
    end

    $display("Checks: %0d, errors: %0d, frames: %0d", checks, errors, sof_count);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
design/render_pkg.sv
design/apb_render_regs.sv
design/pixel_source.sv
design/frame_buffer.sv
design/scan_reader.sv
design/frame_rate_counter.sv
design/render_top.sv
dv/render_tb_sva.sv
dv/render_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the render testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module render_tb \
  -f sim.f \
  -o render_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Compile failed with status $status"
  exit 1
fi

./obj_dir/render_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "No result line in $LOG"
  exit 1
fi

exit 0
